// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = float_unit_tb
FILELIST  = sim.f
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/float_unit.sv
`timescale 1ns/1ps

module float_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           vldin,
    input  fpu_pkg::oper_t oper,
    input  fpu_pkg::fp_t   src0,
    input  fpu_pkg::fp_t   src1,
    output fpu_pkg::fp_t   result,
    output logic           vldout,
    output logic           div_busy
);
    import fpu_pkg::*;

    fp_t  src1_addend;
    fp_t  add_out;
    fp_t  mul_out;
    fp_t  div_out;
    fp_t  next_result;
    logic src0_gt;
    logic src1_gt;
    logic div_start;
    logic div_done;

    // subtract is an add with the sign of src1 flipped.
    assign src1_addend = (oper == OP_SUB) ? {~src1[31], src1[30:0]} : src1;
    assign div_start = vldin && (oper == OP_DIV);

    fp_compare u_gt0 (.a(src0), .b(src1), .gt(src0_gt));
    fp_compare u_gt1 (.a(src1), .b(src0), .gt(src1_gt));

    fp_adder u_add (.a(src0), .b(src1_addend), .sum(add_out));

    fp_multiplier u_mul (.a(src0), .b(src1), .product(mul_out));

    fp_divider u_div (
        .clk      (clk),
        .reset    (reset),
        .start    (div_start),
        .a        (src0),
        .b        (src1),
        .quotient (div_out),
        .done     (div_done),
        .busy     (div_busy)
    );

    // min and max both fall back to src1 when the operands compare equal.
    always_comb begin
        case (oper)
            OP_ADD, OP_SUB: next_result = add_out;
            OP_MUL:         next_result = mul_out;
            OP_ABS:         next_result = {1'b0, src0[30:0]};
            OP_NEG:         next_result = {~src0[31], src0[30:0]};
            OP_MAX:         next_result = src0_gt ? src0 : src1;
            OP_MIN:         next_result = src1_gt ? src0 : src1;
            default:        next_result = '0;
        endcase
    end

    // a finishing divide wins the output register over a same-cycle strobe.
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            vldout <= 1'b0;
        end else begin
            vldout <= div_done || (vldin && !div_start);
            if (div_done) begin
                result <= div_out;
            end else if (vldin && !div_start) begin
                result <= next_result;
            end
        end
    end

endmodule

// File: hw/fp_adder.sv
`timescale 1ns/1ps

module fp_adder (
    input  fpu_pkg::fp_t a,
    input  fpu_pkg::fp_t b,
    output fpu_pkg::fp_t sum
);
    import fpu_pkg::*;

    fp_fields_t        fa;
    fp_fields_t        fb;
    fp_fields_t        op_hi;
    fp_fields_t        op_lo;
    logic              a_larger;
    logic [7:0]        shift;
    logic [25:0]       hi_sig;
    logic [25:0]       lo_sig;
    logic [25:0]       aligned;
    logic [26:0]       raw;
    logic [4:0]        lz;
    logic [25:0]       norm;
    logic signed [9:0] exp_out;

    function automatic logic [4:0] count_lz(input logic [25:0] v);
        logic [4:0] n;
        logic       found;
        n = 5'd0;
        found = 1'b0;
        for (int i = 25; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 5'd1;
            end
        end
        return n;
    endfunction

    assign fa = a;
    assign fb = b;

    // the larger magnitude goes first so the significand difference never goes negative.
    assign a_larger = {fa.exp, fa.mant} >= {fb.exp, fb.mant};
    assign op_hi = a_larger ? fa : fb;
    assign op_lo = a_larger ? fb : fa;
    assign shift = op_hi.exp - op_lo.exp;

    // two guard bits below the significand keep a little precision through alignment.
    assign hi_sig = (op_hi.exp == 8'd0) ? '0 : {1'b1, op_hi.mant, 2'b00};
    assign lo_sig = (op_lo.exp == 8'd0) ? '0 : {1'b1, op_lo.mant, 2'b00};
    assign aligned = lo_sig >> shift;

    assign raw = (op_hi.sign == op_lo.sign) ? {1'b0, hi_sig} + {1'b0, aligned}
                                            : {1'b0, hi_sig} - {1'b0, aligned};

    assign lz = count_lz(raw[25:0]);
    assign norm = raw[25:0] << lz;

    always_comb begin
        if (raw[26]) begin
            exp_out = {2'b00, op_hi.exp} + 10'd1;
        end else begin
            exp_out = {2'b00, op_hi.exp} - {5'd0, lz};
        end

        if (raw == '0) begin
            // exact cancellation gives positive zero.
            sum = '0;
        end else if (exp_out <= 0) begin
            sum = {op_hi.sign, 31'd0};
        end else if (exp_out >= 255) begin
            sum = {op_hi.sign, FP_MAX_MAG};
        end else if (raw[26]) begin
            sum = {op_hi.sign, exp_out[7:0], raw[25:3]};
        end else begin
            sum = {op_hi.sign, exp_out[7:0], norm[24:2]};
        end
    end

endmodule

// File: hw/fp_compare.sv
`timescale 1ns/1ps

module fp_compare (
    input  fpu_pkg::fp_t a,
    input  fpu_pkg::fp_t b,
    output logic         gt
);
    import fpu_pkg::*;

    fp_fields_t  fa;
    fp_fields_t  fb;
    logic [30:0] mag_a;
    logic [30:0] mag_b;

    assign fa = a;
    assign fb = b;

    // a zero exponent counts as zero, so denormals order like zeros.
    assign mag_a = (fa.exp == 8'd0) ? '0 : {fa.exp, fa.mant};
    assign mag_b = (fb.exp == 8'd0) ? '0 : {fb.exp, fb.mant};

    always_comb begin
        if (mag_a == '0 && mag_b == '0) begin
            gt = 1'b0;
        end else if (fa.sign != fb.sign) begin
            gt = ~fa.sign;
        end else if (fa.sign) begin
            // both negative, so the smaller magnitude is the greater number.
            gt = mag_a < mag_b;
        end else begin
            gt = mag_a > mag_b;
        end
    end

endmodule

// File: hw/fp_divider.sv
`timescale 1ns/1ps

module fp_divider (
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  fpu_pkg::fp_t a,
    input  fpu_pkg::fp_t b,
    output fpu_pkg::fp_t quotient,
    output logic         done,
    output logic         busy
);
    import fpu_pkg::*;

    localparam int STEP_W = $clog2(DIV_LATENCY);

    // one capture cycle and one pack cycle surround the iterations, so done
    // comes DIV_LATENCY - 1 cycles after start.
    localparam int LAST_STEP = DIV_LATENCY - 3;

    div_state_e           state;
    logic [STEP_W-1:0]    step;
    fp_fields_t           fa;
    fp_fields_t           fb;
    logic                 q_sign;
    logic                 q_zero;
    logic signed [9:0]    q_exp;
    logic [24:0]          rem;
    logic [23:0]          divisor;
    logic [DIV_QBITS-1:0] quo;
    logic [25:0]          trial;
    logic signed [9:0]    pack_exp;
    logic [22:0]          pack_mant;

    assign fa = a;
    assign fb = b;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
            step <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_ITER;
                        step <= '0;
                    end
                end
                DIV_ITER: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(LAST_STEP)) begin
                        state <= DIV_PACK;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // the top bit of trial is the borrow of the restoring subtraction.
    assign trial = {1'b0, rem} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            q_sign <= fa.sign ^ fb.sign;
            q_zero <= (fa.exp == 8'd0) || (fb.exp == 8'd0);
            q_exp <= {2'b00, fa.exp} - {2'b00, fb.exp} + {2'b00, EXP_BIAS};
            rem <= {2'b01, fa.mant};
            divisor <= {1'b1, fb.mant};
            quo <= '0;
        end else if (state == DIV_ITER) begin
            if (trial[25]) begin
                rem <= {rem[23:0], 1'b0};
                quo <= {quo[DIV_QBITS-2:0], 1'b0};
            end else begin
                rem <= {trial[23:0], 1'b0};
                quo <= {quo[DIV_QBITS-2:0], 1'b1};
            end
        end
    end

    // the first quotient bit has weight one, and the ratio lies in (0.5, 2).
    always_comb begin
        if (quo[DIV_QBITS-1]) begin
            pack_exp = q_exp;
            pack_mant = quo[DIV_QBITS-2 -: 23];
        end else begin
            pack_exp = q_exp - 10'sd1;
            pack_mant = quo[DIV_QBITS-3 -: 23];
        end

        if (q_zero || pack_exp <= 0) begin
            quotient = {q_sign, 31'd0};
        end else if (pack_exp >= 255) begin
            quotient = {q_sign, FP_MAX_MAG};
        end else begin
            quotient = {q_sign, pack_exp[7:0], pack_mant};
        end
    end

    assign done = (state == DIV_PACK);
    assign busy = (state != DIV_IDLE);

endmodule

// File: hw/fp_multiplier.sv
`timescale 1ns/1ps

module fp_multiplier (
    input  fpu_pkg::fp_t a,
    input  fpu_pkg::fp_t b,
    output fpu_pkg::fp_t product
);
    import fpu_pkg::*;

    fp_fields_t        fa;
    fp_fields_t        fb;
    logic              p_sign;
    logic              any_zero;
    logic [47:0]       prod;
    logic signed [9:0] exp_sum;
    logic signed [9:0] exp_out;
    logic [22:0]       mant_out;

    assign fa = a;
    assign fb = b;

    assign p_sign = fa.sign ^ fb.sign;
    assign any_zero = (fa.exp == 8'd0) || (fb.exp == 8'd0);

    assign prod = {1'b1, fa.mant} * {1'b1, fb.mant};
    assign exp_sum = {2'b00, fa.exp} + {2'b00, fb.exp} - {2'b00, EXP_BIAS};

    // the product of two significands in [1,2) lies in [1,4), so one shift is enough.
    always_comb begin
        if (prod[47]) begin
            exp_out = exp_sum + 10'sd1;
            mant_out = prod[46:24];
        end else begin
            exp_out = exp_sum;
            mant_out = prod[45:23];
        end
    end

    always_comb begin
        if (any_zero || exp_out <= 0) begin
            product = {p_sign, 31'd0};
        end else if (exp_out >= 255) begin
            product = {p_sign, FP_MAX_MAG};
        end else begin
            product = {p_sign, exp_out[7:0], mant_out};
        end
    end

endmodule

// File: hw/fpu_pkg.sv
package fpu_pkg;

    // one IEEE-754 single-precision word.
    typedef logic [31:0] fp_t;

    // operation code presented with each strobe.
    typedef logic [3:0] oper_t;

    // field view of an fp_t.
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [22:0] mant;
    } fp_fields_t;

    // opcodes; every other code, zero included, is unknown.
    localparam oper_t OP_ADD = 4'd1;
    localparam oper_t OP_SUB = 4'd2;
    localparam oper_t OP_MUL = 4'd3;
    localparam oper_t OP_ABS = 4'd4;
    localparam oper_t OP_MAX = 4'd5;
    localparam oper_t OP_MIN = 4'd6;
    localparam oper_t OP_NEG = 4'd7;
    localparam oper_t OP_DIV = 4'd8;

    localparam logic [7:0] EXP_BIAS = 8'd127;

    // largest finite magnitude, used when an exponent overflows.
    localparam logic [30:0] FP_MAX_MAG = 31'h7f7f_ffff;

    // quotient bits produced by the divider, 24 significand bits plus two guard bits.
    localparam int DIV_QBITS = 26;

    // cycles from an accepted divide strobe to the vldout pulse of the unit.
    localparam int DIV_LATENCY = DIV_QBITS + 2;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ITER,
        DIV_PACK
    } div_state_e;

endpackage

// File: sim.f
hw/fpu_pkg.sv
hw/fp_compare.sv
hw/fp_adder.sv
hw/fp_multiplier.sv
hw/fp_divider.sv
hw/float_unit.sv
tb/float_unit_chk.sv
tb/float_unit_tb.sv

// File: tb/float_unit_chk.sv
`timescale 1ns/1ps

module float_unit_chk (
    input logic           clk,
    input logic           reset,
    input logic           vldin,
    input fpu_pkg::oper_t oper,
    input logic           div_done,
    input logic           vldout,
    input logic           div_busy
);
    import fpu_pkg::*;

    logic div_start;
    int   failures = 0;

    assign div_start = vldin && (oper == OP_DIV);

    a_reset_clears: assert property (@(posedge clk) reset |=> !vldout)
        else begin
            $error("vldout high in the cycle after reset");
            failures++;
        end

    a_busy_needs_start: assert property (@(posedge clk) disable iff (reset)
        $rose(div_busy) |-> $past(div_start))
        else begin
            $error("div_busy rose without a divide start");
            failures++;
        end

    a_single_cycle: assert property (@(posedge clk) disable iff (reset)
        vldin && !div_start |=> vldout)
        else begin
            $error("no vldout one cycle after a single-cycle strobe");
            failures++;
        end

    // a divide accepted while idle finishes a fixed number of cycles later.
    a_div_latency: assert property (@(posedge clk) disable iff (reset)
        div_start && !div_busy |-> ##DIV_LATENCY vldout)
        else begin
            $error("divide vldout missing after DIV_LATENCY cycles");
            failures++;
        end

    // the caller must leave the cycle of a finishing divide free of strobes.
    a_no_collision: assert property (@(posedge clk) disable iff (reset)
        !(vldin && div_done))
        else begin
            $error("strobe issued in the cycle a divide completes");
            failures++;
        end

endmodule

bind float_unit float_unit_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .vldin    (vldin),
    .oper     (oper),
    .div_done (div_done),
    .vldout   (vldout),
    .div_busy (div_busy)
);

// File: tb/float_unit_tb.sv
`timescale 1ns/1ps

module float_unit_tb;
    import fpu_pkg::*;

    localparam int WAIT_LIMIT = 4 * DIV_LATENCY;

    logic  clk = 1'b0;
    logic  reset;
    logic  vldin;
    oper_t oper;
    fp_t   src0;
    fp_t   src1;
    fp_t   result;
    logic  vldout;
    logic  div_busy;
    int    seed;
    int    checks;
    int    errors;

    float_unit dut (
        .clk      (clk),
        .reset    (reset),
        .vldin    (vldin),
        .oper     (oper),
        .src0     (src0),
        .src1     (src1),
        .result   (result),
        .vldout   (vldout),
        .div_busy (div_busy)
    );

    always #4 clk = ~clk;

    // encodes v * 2^e for a small integer v, exact while |v| stays below 2^24.
    function automatic fp_t to_fp(input int v, input int e);
        fp_fields_t f;
        int         m;
        int         p;
        f = '0;
        if (v == 0) begin
            return '0;
        end
        f.sign = (v < 0);
        m = (v < 0) ? -v : v;
        p = 0;
        for (int i = 0; i < 24; i++) begin
            if (m[i]) begin
                p = i;
            end
        end
        f.exp = 8'(p + e + 127);
        f.mant = 23'((m << (23 - p)) & 32'h007f_ffff);
        return f;
    endfunction

    task automatic check_fp(input string name, input fp_t expected, input fp_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic issue(input oper_t op, input fp_t a, input fp_t b);
        vldin <= 1'b1;
        oper <= op;
        src0 <= a;
        src1 <= b;
    endtask

    // latency counts rising edges from the edge that drives the strobe.
    task automatic run_op(input string name, input oper_t op, input fp_t a, input fp_t b,
                          input fp_t expected, input int latency);
        int cycles;
        cycles = 0;
        @(posedge clk);
        issue(op, a, b);
        while (cycles < WAIT_LIMIT) begin
            @(posedge clk);
            vldin <= 1'b0;
            cycles++;
            @(negedge clk);
            if (vldout) begin
                break;
            end
            if (op == OP_DIV && !div_busy) begin
                errors++;
                $display("div_busy was low while the divide for %s was in progress", name);
            end
        end
        if (!vldout) begin
            errors++;
            $display("timed out waiting for vldout in %s", name);
        end else begin
            check_fp(name, expected, result);
            check_latency(name, latency, cycles);
        end
    endtask

    task automatic test_add_sub();
        int  va;
        int  vb;
        int  ea;
        int  eb;
        int  emin;
        int  ia;
        int  ib;
        fp_t fa;
        fp_t fb;
        for (int i = 0; i < 12; i++) begin
            va = $random(seed) % 16;
            vb = $random(seed) % 16;
            ea = $random(seed) % 4;
            eb = $random(seed) % 4;
            emin = (ea < eb) ? ea : eb;
            ia = va * (1 << (ea - emin));
            ib = vb * (1 << (eb - emin));
            fa = to_fp(va, ea);
            fb = to_fp(vb, eb);
            run_op("add", OP_ADD, fa, fb, to_fp(ia + ib, emin), 1);
            run_op("sub", OP_SUB, fa, fb, to_fp(ia - ib, emin), 1);
        end
        run_op("add_cancel", OP_ADD, to_fp(3, 1), to_fp(-3, 1), 32'h0, 1);
        run_op("sub_cancel", OP_SUB, to_fp(-5, -2), to_fp(-5, -2), 32'h0, 1);
    endtask

    task automatic test_mul();
        int  va;
        int  vb;
        int  ea;
        int  eb;
        fp_t fa;
        fp_t fb;
        fp_t expected;
        for (int i = 0; i < 12; i++) begin
            va = $random(seed) % 16;
            vb = $random(seed) % 16;
            ea = $random(seed) % 4;
            eb = $random(seed) % 4;
            fa = to_fp(va, ea);
            fb = to_fp(vb, eb);
            if (va == 0 || vb == 0) begin
                expected = {fa[31] ^ fb[31], 31'd0};
            end else begin
                expected = to_fp(va * vb, ea + eb);
            end
            run_op("mul", OP_MUL, fa, fb, expected, 1);
        end
        run_op("mul_zero", OP_MUL, 32'h0, to_fp(-5, 0), 32'h8000_0000, 1);
        run_op("mul_neg_zero", OP_MUL, 32'h8000_0000, to_fp(-2, 0), 32'h0, 1);
    endtask

    task automatic test_sign_minmax();
        run_op("abs", OP_ABS, to_fp(-3, 0), to_fp(2, 0), to_fp(3, 0), 1);
        run_op("abs_pos", OP_ABS, to_fp(5, -1), to_fp(-1, 0), to_fp(5, -1), 1);
        run_op("neg", OP_NEG, to_fp(2, 0), to_fp(-3, 0), to_fp(-2, 0), 1);
        run_op("neg_neg", OP_NEG, to_fp(-7, 2), to_fp(1, 0), to_fp(7, 2), 1);
        run_op("max_mixed", OP_MAX, to_fp(2, 0), to_fp(-3, 0), to_fp(2, 0), 1);
        run_op("min_mixed", OP_MIN, to_fp(2, 0), to_fp(-3, 0), to_fp(-3, 0), 1);
        run_op("max_neg", OP_MAX, to_fp(-3, -1), to_fp(-1, -1), to_fp(-1, -1), 1);
        run_op("min_neg", OP_MIN, to_fp(-3, -1), to_fp(-1, -1), to_fp(-3, -1), 1);
        // the zeros compare equal, so both results come from src1.
        run_op("max_zero", OP_MAX, 32'h0, 32'h8000_0000, 32'h8000_0000, 1);
        run_op("min_zero", OP_MIN, 32'h0, 32'h8000_0000, 32'h8000_0000, 1);
    endtask

    task automatic test_div();
        run_op("div_12_m3", OP_DIV, to_fp(12, 0), to_fp(-3, 0), to_fp(-4, 0), DIV_LATENCY);
        run_op("div_1_4", OP_DIV, to_fp(1, 0), to_fp(4, 0), to_fp(1, -2), DIV_LATENCY);
        run_op("div_9_6", OP_DIV, to_fp(9, 0), to_fp(6, 0), to_fp(3, -1), DIV_LATENCY);
        run_op("div_m10_m5", OP_DIV, to_fp(-10, 0), to_fp(-5, 0), to_fp(2, 0), DIV_LATENCY);
    endtask

    task automatic test_zero_results();
        run_op("div_by_zero", OP_DIV, to_fp(-5, 0), 32'h0, 32'h8000_0000, DIV_LATENCY);
        run_op("unknown_0", 4'd0, to_fp(7, 0), to_fp(2, 0), 32'h0, 1);
        run_op("unknown_9", 4'd9, to_fp(7, 0), to_fp(2, 0), 32'h0, 1);
        run_op("unknown_15", 4'd15, to_fp(7, 0), to_fp(2, 0), 32'h0, 1);
    endtask

    // a new strobe goes out every cycle and each result is checked one cycle after its strobe.
    task automatic test_back_to_back();
        oper_t ops[5];
        fp_t   a[5];
        fp_t   b[5];
        fp_t   expected[5];
        ops = '{OP_ADD, OP_MUL, OP_NEG, OP_MAX, OP_SUB};
        a = '{to_fp(2, 0), to_fp(2, 0), to_fp(2, 0), to_fp(2, 0), to_fp(6, -1)};
        b = '{to_fp(3, 0), to_fp(-3, 0), to_fp(5, 0), to_fp(-3, 0), to_fp(1, 0)};
        expected = '{to_fp(5, 0), to_fp(-6, 0), to_fp(-2, 0), to_fp(2, 0), to_fp(2, 0)};
        for (int k = 0; k <= 5; k++) begin
            @(posedge clk);
            if (k < 5) begin
                issue(ops[k], a[k], b[k]);
            end else begin
                vldin <= 1'b0;
            end
            @(negedge clk);
            if (k >= 1) begin
                if (!vldout) begin
                    errors++;
                    $display("vldout missing for back-to-back strobe %0d", k - 1);
                end
                check_fp("back_to_back", expected[k-1], result);
            end
        end
    endtask

    initial begin
        seed = 70;
        checks = 0;
        errors = 0;
        reset = 1'b1;
        vldin = 1'b0;
        oper = '0;
        src0 = '0;
        src1 = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_add_sub();
        test_mul();
        test_sign_minmax();
        test_div();
        test_zero_results();
        test_back_to_back();
        repeat (2) @(posedge clk);
        errors += dut.u_chk.failures;
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
